// ==== dv/issue_checker.sv ====
// ----------------------------------------------------------------------
// Protocol assertions for issue_top, attached by bind. fail_cnt holds
// the number of failed assertions.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module issue_checker (
  input logic                        clk,
  input logic                        rst,
  input logic                        inst_val,
  input logic [`ISSUE_INST_BITS-1:0] inst,
  input logic [`ISSUE_XLEN-1:0]      pc,
  input logic                        inst_rdy,
  input logic                        illegal_pulse,
  input logic                        wb_val,
  input logic [`ISSUE_REG_BITS-1:0]  wb_waddr,
  input logic [`ISSUE_NUM_PIPES-1:0] issue_val
);

  int fail_cnt = 0;

  // Offer held while stalled
  a_offer_stable: assert property (@(posedge clk) disable iff (rst)
    (inst_val && !inst_rdy) |=> ($stable(inst) && $stable(pc)))
    else begin
      fail_cnt++;
      $error("inst or pc changed while inst_val high and inst_rdy low");
    end

  // x0 is never written
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb_val |-> (wb_waddr != '0))
    else begin
      fail_cnt++;
      $error("writeback to x0");
    end

  // Outputs already cleared from the second reset edge onward
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!wb_val && !illegal_pulse))
    else begin
      fail_cnt++;
      $error("wb_val or illegal_pulse high during reset");
    end

  // At most one pipe selected
  a_issue_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(issue_val))
    else begin
      fail_cnt++;
      $error("issue_val has more than one bit set");
    end

endmodule

bind issue_top issue_checker u_checker (
  .clk           (clk),
  .rst           (rst),
  .inst_val      (inst_val),
  .inst          (inst),
  .pc            (pc),
  .inst_rdy      (inst_rdy),
  .illegal_pulse (illegal_pulse),
  .wb_val        (wb_val),
  .wb_waddr      (wb_waddr),
  .issue_val     (issue_val)
);

`default_nettype wire

// ==== dv/issue_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for issue_top. Inputs change on the falling edge, outputs
// are sampled there too. In-order model with one expected-write queue,
// matched per destination register.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module issue_tb;

  localparam int RESET_LIMIT  = 40;
  localparam int ACCEPT_LIMIT = 64;
  localparam int DRAIN_LIMIT  = 200;

  logic                        clk;
  logic                        rst;
  logic                        inst_val;
  logic [`ISSUE_INST_BITS-1:0] inst;
  logic [`ISSUE_XLEN-1:0]      pc;
  logic                        inst_rdy;
  logic                        illegal_pulse;
  logic                        wb_val;
  logic [`ISSUE_XLEN-1:0]      wb_pc;
  logic [`ISSUE_REG_BITS-1:0]  wb_waddr;
  logic [`ISSUE_XLEN-1:0]      wb_data;

  tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  issue_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .inst_val      (inst_val),
    .inst          (inst),
    .pc            (pc),
    .inst_rdy      (inst_rdy),
    .illegal_pulse (illegal_pulse),
    .wb_val        (wb_val),
    .wb_pc         (wb_pc),
    .wb_waddr      (wb_waddr),
    .wb_data       (wb_data)
  );

  // ----------------------------------------------------------------------
  // Model state and bookkeeping
  // ----------------------------------------------------------------------

  logic [`ISSUE_XLEN-1:0] mrf [32];
  // Entry is {waddr, pc, data}
  logic [68:0]            exp_q [$];
  logic                   exp_illegal;
  logic [31:0]            lfsr_q;
  logic [`ISSUE_XLEN-1:0] next_pc;
  int                     errors;
  int                     checks;
  int                     tests;
  int                     test_base;
  int                     stall_cnt;
  logic                   aborted;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Registers x0..x15 only to keep hazards frequent
  function automatic int rand_reg();
    return int'(rand_bits(4));
  endfunction

  // R-type with funct3 zero
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rd,
                                        input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `ISSUE_OPC_OP};
  endfunction

  // ADDI
  function automatic logic [31:0] enc_i(input int imm, input int rd, input int rs1);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `ISSUE_OPC_OPIMM};
  endfunction

  // Register still waiting for its modelled writeback
  function automatic logic owed(input logic [4:0] r);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i][68:64] == r) hit = 1'b1;
    end
    return hit;
  endfunction

  // Ready level forced by decode and the pending registers, if any
  task automatic ready_rule(input logic [31:0] word, output logic known,
                            output logic exp);
    logic is_op;
    logic is_r;
    logic is_addi;
    logic hazard;
    is_op   = (word[6:0] == 7'b0110011) && (word[14:12] == 3'b000);
    is_r    = is_op && (word[31:25] == 7'b0000000 || word[31:25] == 7'b0000001);
    is_addi = (word[6:0] == 7'b0010011) && (word[14:12] == 3'b000);
    hazard  = owed(word[19:15]) || owed(word[11:7]) ||
              (is_r && owed(word[24:20]));
    known   = 1'b1;
    exp     = 1'b0;
    if (!(is_r || is_addi) || word[11:7] == 5'd0) exp = 1'b1;
    else if (!hazard) known = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  task automatic check_illegal(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: illegal_pulse %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_rdy(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: inst_rdy %b, expected %b", $time, got, exp);
    end
  endtask

  // Oldest expected write to the same register must match
  task automatic check_wb(input logic [`ISSUE_REG_BITS-1:0] waddr,
                          input logic [`ISSUE_XLEN-1:0] pc_got,
                          input logic [`ISSUE_XLEN-1:0] data_got);
    int idx;
    idx = -1;
    checks++;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i][68:64] == waddr) idx = i;
    end
    if (idx < 0) begin
      errors++;
      $display("MISMATCH at %0t: unexpected write x%0d pc %h data %h",
               $time, waddr, pc_got, data_got);
    end else begin
      if (exp_q[idx][63:32] !== pc_got || exp_q[idx][31:0] !== data_got) begin
        errors++;
        $display("MISMATCH at %0t: x%0d got pc %h data %h, expected pc %h data %h",
                 $time, waddr, pc_got, data_got, exp_q[idx][63:32], exp_q[idx][31:0]);
      end
      exp_q.delete(idx);
    end
  endtask

  task automatic timeout_hit(input string what);
    errors++;
    aborted = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  // ----------------------------------------------------------------------
  // Model and drivers
  // ----------------------------------------------------------------------

  // Architectural effect of one accepted instruction
  task automatic apply_model(input logic [31:0] word, input logic [`ISSUE_XLEN-1:0] pc_in);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    logic [63:0] prod;
    logic        is_op;
    logic        is_add;
    logic        is_mul;
    logic        is_addi;
    rd      = word[11:7];
    is_op   = (word[6:0] == 7'b0110011) && (word[14:12] == 3'b000);
    is_add  = is_op && (word[31:25] == 7'b0000000);
    is_mul  = is_op && (word[31:25] == 7'b0000001);
    is_addi = (word[6:0] == 7'b0010011) && (word[14:12] == 3'b000);
    if (!(is_add || is_mul || is_addi)) begin
      exp_illegal = 1'b1;
      return;
    end
    if (rd == 5'd0) return;
    a = mrf[word[19:15]];
    b = is_addi ? {{20{word[31]}}, word[31:20]} : mrf[word[24:20]];
    prod = {32'b0, a} * {32'b0, b};
    data = is_mul ? prod[31:0] : a + b;
    mrf[rd] = data;
    exp_q.push_back({rd, pc_in, data});
  endtask

  // One clock, then check what the last rising edge produced
  task automatic advance_cycle();
    @(negedge clk);
    if (!rst) begin
      check_illegal(illegal_pulse, exp_illegal);
      exp_illegal = 1'b0;
      if (wb_val) check_wb(wb_waddr, wb_pc, wb_data);
    end
  endtask

  // Idle gap, then offer until taken
  task automatic send_inst(input logic [31:0] word, input int gap);
    int   n;
    logic taken;
    logic rdy_known;
    logic rdy_exp;
    if (aborted) return;
    for (n = 0; n < gap; n++) advance_cycle();
    inst_val = 1'b1;
    inst     = word;
    pc       = next_pc;
    taken    = 1'b0;
    n        = 0;
    while (!taken && n < ACCEPT_LIMIT) begin
      // Ready is settled well before the rising edge
      #1;
      ready_rule(word, rdy_known, rdy_exp);
      if (rdy_known) check_rdy(inst_rdy, rdy_exp);
      taken = inst_rdy;
      if (taken) apply_model(word, next_pc);
      else stall_cnt++;
      advance_cycle();
      n++;
    end
    inst_val = 1'b0;
    next_pc  = next_pc + 4;
    if (!taken) timeout_hit("instruction never accepted");
  endtask

  task automatic drain();
    int n;
    if (aborted) return;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      advance_cycle();
      n++;
    end
    if (exp_q.size() != 0) timeout_hit("expected writebacks never appeared");
    // Quiet window for stray writes and pulses
    else repeat (4) advance_cycle();
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - test_base);
    test_base = errors;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic run_addi_chain();
    int imms [5] = '{100, -300, 2047, -2048, -1};
    for (int i = 0; i < 5; i++) send_inst(enc_i(imms[i], i + 1, i), 0);
    drain();
  endtask

  task automatic run_add_deps();
    stall_cnt = 0;
    send_inst(enc_r(`ISSUE_F7_BASE, 6, 1, 2), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 7, 6, 6), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 8, 7, 1), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 6, 8, 6), 0);
    drain();
    if (!aborted && stall_cnt == 0) begin
      errors++;
      $display("Dependent ADD chain never saw inst_rdy low");
    end
  endtask

  // Independent ADD may retire ahead of the MUL
  task automatic run_mul_mix();
    send_inst(enc_r(`ISSUE_F7_MULDIV, 9, 3, 4), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 10, 1, 2), 0);
    send_inst(enc_r(`ISSUE_F7_MULDIV, 11, 9, 9), 0);
    send_inst(enc_r(`ISSUE_F7_MULDIV, 12, 4, 5), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 13, 12, 10), 0);
    drain();
  endtask

  task automatic run_random_mix();
    logic [31:0] sel;
    logic [31:0] g;
    int          gap;
    int          rd;
    int          rs1;
    int          rs2;
    int          imm;
    for (int i = 0; i < 300; i++) begin
      sel = rand_bits(2);
      g   = rand_bits(3);
      rd  = rand_reg();
      rs1 = rand_reg();
      rs2 = rand_reg();
      imm = int'(rand_bits(12));
      gap = (g > 4) ? int'(g) - 4 : 0;
      case (sel[1:0])
        2'd0:    send_inst(enc_r(`ISSUE_F7_BASE, rd, rs1, rs2), gap);
        2'd2:    send_inst(enc_r(`ISSUE_F7_MULDIV, rd, rs1, rs2), gap);
        default: send_inst(enc_i(imm, rd, rs1), gap);
      endcase
    end
    drain();
  endtask

  task automatic run_illegal_x0();
    // Illegal lw, sub, sll, andi, div and an all-zero word
    send_inst(32'h0040_a183, 0);
    send_inst(32'h4020_8233, 1);
    send_inst(32'h0020_9233, 0);
    send_inst(32'h0ff0_f293, 0);
    send_inst(32'h0220_c233, 2);
    send_inst(32'h0000_0000, 0);
    // Writes to x0 vanish
    send_inst(enc_i(77, 0, 1), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 0, 2, 3), 0);
    send_inst(enc_r(`ISSUE_F7_MULDIV, 0, 3, 4), 0);
    send_inst(enc_i(9, 14, 0), 0);
    send_inst(enc_r(`ISSUE_F7_BASE, 15, 0, 0), 0);
    drain();
  endtask

  initial begin
    int n;
    inst_val    = 1'b0;
    inst        = '0;
    pc          = '0;
    lfsr_q      = 32'hd98b_4d85;
    next_pc     = 32'h0000_1000;
    exp_illegal = 1'b0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_base   = 0;
    stall_cnt   = 0;
    aborted     = 1'b0;
    for (int i = 0; i < 32; i++) mrf[i] = '0;

    n = 0;
    while (rst !== 1'b0 && n < RESET_LIMIT) begin
      advance_cycle();
      n++;
    end
    if (rst !== 1'b0) timeout_hit("reset never released");

    run_addi_chain();
    report_test("addi_chain");
    run_add_deps();
    report_test("add_dependencies");
    run_mul_mix();
    report_test("mul_mix");
    run_random_mix();
    report_test("random_mix");
    run_illegal_x0();
    report_test("illegal_and_x0");

    // Assertion failures from the bound checker
    errors = errors + u_dut.u_checker.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
// ----------------------------------------------------------------------
// Clock and reset source for the testbench. 100 ns period, reset high
// for the first 10 rising edges and released on a falling edge.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/issue_pkg.sv
rtl/decode_issue.sv
rtl/exec_pipe.sv
rtl/writeback_arb.sv
rtl/issue_top.sv
dv/tb_clkgen.sv
dv/issue_checker.sv
dv/issue_tb.sv

// ==== include/issue_consts.svh ====
// ----------------------------------------------------------------------
// Sizing and encoding constants for the decode-and-issue subsystem.
// ISSUE_MUL_LAT must be 1 or more. Pipe count is limited only by area.
// ----------------------------------------------------------------------
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// Datapath sizing
`define ISSUE_NUM_PIPES 3
`define ISSUE_MUL_LAT   2
`define ISSUE_XLEN      32
`define ISSUE_INST_BITS 32
`define ISSUE_REG_BITS  5

// RV32 encodings for the supported subset
`define ISSUE_OPC_OP     7'b0110011
`define ISSUE_OPC_OPIMM  7'b0010011
`define ISSUE_F7_BASE    7'b0000000
`define ISSUE_F7_MULDIV  7'b0000001

`endif

// ==== rtl/decode_issue.sv ====
// ----------------------------------------------------------------------
// In-order decode and issue for ADD, ADDI and MUL. No bypassing; any
// pending source or destination stalls. Illegal or x0-destination
// instructions are consumed without issue.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module decode_issue (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          inst_val,
  input  logic [`ISSUE_INST_BITS-1:0]   inst,
  input  logic [`ISSUE_XLEN-1:0]        pc,
  output logic                          inst_rdy,
  output logic                          illegal_pulse,
  input  logic [`ISSUE_NUM_PIPES-1:0]   pipe_idle,
  output logic [`ISSUE_NUM_PIPES-1:0]   issue_val,
  output issue_pkg::uop_e               issue_uop,
  output logic [`ISSUE_XLEN-1:0]        issue_op1,
  output logic [`ISSUE_XLEN-1:0]        issue_op2,
  output logic [`ISSUE_XLEN-1:0]        issue_pc,
  output logic [`ISSUE_REG_BITS-1:0]    issue_waddr,
  input  logic                          rf_wen,
  input  logic [`ISSUE_REG_BITS-1:0]    rf_waddr,
  input  logic [`ISSUE_XLEN-1:0]        rf_wdata
);
  import issue_pkg::*;

  localparam int NUM_REGS = 1 << `ISSUE_REG_BITS;

  // ----------------------------------------------------------------------
  // Field extraction and decode
  // ----------------------------------------------------------------------

  logic [6:0]                 opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [`ISSUE_REG_BITS-1:0] rd;
  logic [`ISSUE_REG_BITS-1:0] rs1;
  logic [`ISSUE_REG_BITS-1:0] rs2;
  logic [`ISSUE_XLEN-1:0]     imm_i;
  logic                       is_add;
  logic                       is_mul;
  logic                       is_addi;
  logic                       legal;
  logic                       uses_rs2;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // I-type immediate, sign extended
  assign imm_i = {{(`ISSUE_XLEN-12){inst[31]}}, inst[31:20]};

  assign is_add  = (opcode == `ISSUE_OPC_OP) && (funct3 == 3'b000) &&
                   (funct7 == `ISSUE_F7_BASE);
  assign is_mul  = (opcode == `ISSUE_OPC_OP) && (funct3 == 3'b000) &&
                   (funct7 == `ISSUE_F7_MULDIV);
  assign is_addi = (opcode == `ISSUE_OPC_OPIMM) && (funct3 == 3'b000);

  assign legal    = is_add | is_mul | is_addi;
  assign uses_rs2 = is_add | is_mul;

  // ----------------------------------------------------------------------
  // Register file and scoreboard
  // ----------------------------------------------------------------------

  logic [`ISSUE_XLEN-1:0] rf [NUM_REGS];
  logic [NUM_REGS-1:0]    pending;
  logic [NUM_REGS-1:0]    pend_set;
  logic [NUM_REGS-1:0]    pend_clr;
  logic [`ISSUE_XLEN-1:0] rs1_data;
  logic [`ISSUE_XLEN-1:0] rs2_data;

  // Writeback port keeps x0 at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (rf_wen && (rf_waddr != '0)) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : rf[rs2];

  // ----------------------------------------------------------------------
  // Hazards, handshake and pipe select
  // ----------------------------------------------------------------------

  logic                        run_q;
  logic                        raw_hazard;
  logic                        waw_hazard;
  logic                        wb_hazard;
  logic                        rd_zero;
  logic                        fire;
  logic                        do_issue;
  logic [`ISSUE_NUM_PIPES-1:0] pipe_sel;

  assign raw_hazard = pending[rs1] | (uses_rs2 & pending[rs2]);
  assign waw_hazard = pending[rd];
  // Register being written this cycle has not reached the file yet
  assign wb_hazard  = rf_wen & ((rf_waddr == rs1) | (uses_rs2 & (rf_waddr == rs2)));
  assign rd_zero    = (rd == '0);

  // Nothing to issue for illegal or x0 writes, so always take them
  assign inst_rdy = run_q & (~legal | rd_zero |
                    (~raw_hazard & ~waw_hazard & ~wb_hazard & (|pipe_idle)));

  assign fire     = inst_val & inst_rdy;
  assign do_issue = fire & legal & ~rd_zero;

  // Lowest set bit of the idle mask
  assign pipe_sel  = pipe_idle & (~pipe_idle + 1'b1);
  assign issue_val = do_issue ? pipe_sel : '0;

  // Shared payload for every pipe
  assign issue_uop   = is_mul ? UOP_MUL : UOP_ADD;
  assign issue_op1   = rs1_data;
  assign issue_op2   = is_addi ? imm_i : rs2_data;
  assign issue_pc    = pc;
  assign issue_waddr = rd;

  // Set wins over a clear of the same bit
  always_comb begin
    pend_set = '0;
    pend_clr = '0;
    if (do_issue) pend_set[rd] = 1'b1;
    if (rf_wen)   pend_clr[rf_waddr] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q         <= 1'b0;
      pending       <= '0;
      illegal_pulse <= 1'b0;
    end else begin
      run_q         <= 1'b1;
      pending       <= (pending & ~pend_clr) | pend_set;
      illegal_pulse <= fire & ~legal;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exec_pipe.sv ====
// ----------------------------------------------------------------------
// Single execution pipe. ADD is ready one cycle after capture, MUL
// after ISSUE_MUL_LAT cycles. Result is held until acknowledged.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module exec_pipe (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       issue_val,
  input  issue_pkg::uop_e            issue_uop,
  input  logic [`ISSUE_XLEN-1:0]     issue_op1,
  input  logic [`ISSUE_XLEN-1:0]     issue_op2,
  input  logic [`ISSUE_XLEN-1:0]     issue_pc,
  input  logic [`ISSUE_REG_BITS-1:0] issue_waddr,
  output logic                       idle,
  output logic                       res_val,
  output logic [`ISSUE_XLEN-1:0]     res_data,
  output logic [`ISSUE_XLEN-1:0]     res_pc,
  output logic [`ISSUE_REG_BITS-1:0] res_waddr,
  input  logic                       res_ack
);
  import issue_pkg::*;

  localparam int CNT_W = $clog2(`ISSUE_MUL_LAT + 1);

  pipe_state_e            state;
  logic [CNT_W-1:0]       cnt;
  uop_e                   uop_q;
  logic [`ISSUE_XLEN-1:0] op1_q;
  logic [`ISSUE_XLEN-1:0] op2_q;
  logic [`ISSUE_XLEN-1:0] result;

  // Low half of the product only
  assign result = (uop_q == UOP_MUL) ? (op1_q * op2_q) : (op1_q + op2_q);

  // Control FSM with latency counter
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= PIPE_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        PIPE_IDLE: if (issue_val) begin
          state <= PIPE_BUSY;
          cnt   <= (issue_uop == UOP_MUL) ? CNT_W'(`ISSUE_MUL_LAT - 1) : '0;
        end
        PIPE_BUSY: if (cnt == '0) state <= PIPE_DONE;
                   else cnt <= cnt - 1'b1;
        PIPE_DONE: if (res_ack) state <= PIPE_IDLE;
        default:   state <= PIPE_IDLE;
      endcase
    end
  end

  // Operands and tags on capture, result at end of latency
  always_ff @(posedge clk) begin
    if ((state == PIPE_IDLE) && issue_val) begin
      uop_q     <= issue_uop;
      op1_q     <= issue_op1;
      op2_q     <= issue_op2;
      res_pc    <= issue_pc;
      res_waddr <= issue_waddr;
    end
    if ((state == PIPE_BUSY) && (cnt == '0)) res_data <= result;
  end

  assign idle    = (state == PIPE_IDLE);
  assign res_val = (state == PIPE_DONE);

endmodule

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
// ----------------------------------------------------------------------
// Enumerated types shared by the decoder and the execution pipes.
// ADDI has no micro-op of its own and travels as UOP_ADD.
// ----------------------------------------------------------------------
`default_nettype none

package issue_pkg;

  // Micro-op sent from decode to a pipe
  typedef enum logic {
    UOP_ADD = 1'b0,
    UOP_MUL = 1'b1
  } uop_e;

  // Life cycle of one execution pipe
  // IDLE accepts, BUSY counts latency, DONE holds the result
  typedef enum logic [1:0] {
    PIPE_IDLE = 2'd0,
    PIPE_BUSY = 2'd1,
    PIPE_DONE = 2'd2
  } pipe_state_e;

endpackage

`default_nettype wire

// ==== rtl/issue_top.sv ====
// ----------------------------------------------------------------------
// Decode, pipe array and writeback arbiter. Source must hold inst and
// pc while inst_val is high and inst_rdy low. wb_* is a one-cycle pulse.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module issue_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inst_val,
  input  logic [`ISSUE_INST_BITS-1:0] inst,
  input  logic [`ISSUE_XLEN-1:0]      pc,
  output logic                        inst_rdy,
  output logic                        illegal_pulse,
  output logic                        wb_val,
  output logic [`ISSUE_XLEN-1:0]      wb_pc,
  output logic [`ISSUE_REG_BITS-1:0]  wb_waddr,
  output logic [`ISSUE_XLEN-1:0]      wb_data
);
  import issue_pkg::*;

  // Decode to pipes
  logic [`ISSUE_NUM_PIPES-1:0] pipe_idle;
  logic [`ISSUE_NUM_PIPES-1:0] issue_val;
  uop_e                        issue_uop;
  logic [`ISSUE_XLEN-1:0]      issue_op1;
  logic [`ISSUE_XLEN-1:0]      issue_op2;
  logic [`ISSUE_XLEN-1:0]      issue_pc;
  logic [`ISSUE_REG_BITS-1:0]  issue_waddr;

  // Pipes to arbiter
  logic [`ISSUE_NUM_PIPES-1:0] res_val;
  logic [`ISSUE_NUM_PIPES-1:0] res_ack;
  logic [`ISSUE_XLEN-1:0]      res_data  [`ISSUE_NUM_PIPES];
  logic [`ISSUE_XLEN-1:0]      res_pc    [`ISSUE_NUM_PIPES];
  logic [`ISSUE_REG_BITS-1:0]  res_waddr [`ISSUE_NUM_PIPES];

  // Writeback outputs double as the register-file write port
  decode_issue u_decode (
    .clk           (clk),
    .rst           (rst),
    .inst_val      (inst_val),
    .inst          (inst),
    .pc            (pc),
    .inst_rdy      (inst_rdy),
    .illegal_pulse (illegal_pulse),
    .pipe_idle     (pipe_idle),
    .issue_val     (issue_val),
    .issue_uop     (issue_uop),
    .issue_op1     (issue_op1),
    .issue_op2     (issue_op2),
    .issue_pc      (issue_pc),
    .issue_waddr   (issue_waddr),
    .rf_wen        (wb_val),
    .rf_waddr      (wb_waddr),
    .rf_wdata      (wb_data)
  );

  for (genvar i = 0; i < `ISSUE_NUM_PIPES; i++) begin : g_pipe
    exec_pipe u_pipe (
      .clk         (clk),
      .rst         (rst),
      .issue_val   (issue_val[i]),
      .issue_uop   (issue_uop),
      .issue_op1   (issue_op1),
      .issue_op2   (issue_op2),
      .issue_pc    (issue_pc),
      .issue_waddr (issue_waddr),
      .idle        (pipe_idle[i]),
      .res_val     (res_val[i]),
      .res_data    (res_data[i]),
      .res_pc      (res_pc[i]),
      .res_waddr   (res_waddr[i]),
      .res_ack     (res_ack[i])
    );
  end

  writeback_arb u_arb (
    .clk       (clk),
    .rst       (rst),
    .res_val   (res_val),
    .res_data  (res_data),
    .res_pc    (res_pc),
    .res_waddr (res_waddr),
    .res_ack   (res_ack),
    .wb_val    (wb_val),
    .wb_pc     (wb_pc),
    .wb_data   (wb_data),
    .wb_waddr  (wb_waddr)
  );

endmodule

`default_nettype wire

// ==== rtl/writeback_arb.sv ====
// ----------------------------------------------------------------------
// Fixed-priority writeback arbiter, lowest pipe index wins. One write
// per cycle, no back-pressure. Outputs are the register-file port.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "issue_consts.svh"

module writeback_arb (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`ISSUE_NUM_PIPES-1:0] res_val,
  input  logic [`ISSUE_XLEN-1:0]      res_data  [`ISSUE_NUM_PIPES],
  input  logic [`ISSUE_XLEN-1:0]      res_pc    [`ISSUE_NUM_PIPES],
  input  logic [`ISSUE_REG_BITS-1:0]  res_waddr [`ISSUE_NUM_PIPES],
  output logic [`ISSUE_NUM_PIPES-1:0] res_ack,
  output logic                        wb_val,
  output logic [`ISSUE_XLEN-1:0]      wb_pc,
  output logic [`ISSUE_XLEN-1:0]      wb_data,
  output logic [`ISSUE_REG_BITS-1:0]  wb_waddr
);

  logic [`ISSUE_NUM_PIPES-1:0] grant;
  logic [`ISSUE_XLEN-1:0]      sel_data;
  logic [`ISSUE_XLEN-1:0]      sel_pc;
  logic [`ISSUE_REG_BITS-1:0]  sel_waddr;

  // Isolate lowest valid request
  assign grant   = res_val & (~res_val + 1'b1);
  assign res_ack = grant;

  // One-hot mux of the granted lane
  always_comb begin
    sel_data  = '0;
    sel_pc    = '0;
    sel_waddr = '0;
    for (int i = 0; i < `ISSUE_NUM_PIPES; i++) begin
      if (grant[i]) begin
        sel_data  = res_data[i];
        sel_pc    = res_pc[i];
        sel_waddr = res_waddr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) wb_val <= 1'b0;
    else     wb_val <= |res_val;
  end

  // Payload follows the grant and matters only with wb_val
  always_ff @(posedge clk) begin
    if (|res_val) begin
      wb_data  <= sel_data;
      wb_pc    <= sel_pc;
      wb_waddr <= sel_waddr;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the issue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module issue_tb -f filelist.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

# Keep running past assertion errors so the testbench reports them
./obj_dir/Vissue_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qF '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
